// File: hw/SignalGen_defs.svh
// Signal generator widths and timing constants
// Shared by the package and every block of the DDS generator

`ifndef SIGNALGEN_DEFS_SVH
`define SIGNALGEN_DEFS_SVH

// Tuning word, amplitude and output sample
`define SG_WORD_WIDTH 8

// Phase accumulator, fout = tuning * fclk / 2^16
`define SG_PHASE_WIDTH 16

// Overflows per gate, enough for 25 MHz
`define SG_COUNT_WIDTH 24

// Multiplexed display digits
`define SG_DIGITS 8

// Cycles an encoder line must hold before it is accepted
`define SG_ENCODER_STABLE 4

`endif

// File: hw/SignalGenPkg.sv
// Shared types of the DDS signal generator
// Vector widths with a meaning and the structs passed between blocks

`default_nettype none

package SignalGenPkg;

	`include "SignalGen_defs.svh"

	typedef logic [`SG_WORD_WIDTH-1:0]  tuningWord_t;	// Phase step per clock
	typedef logic [`SG_WORD_WIDTH-1:0]  amplitude_t;	// Scale is amplitude / 256
	typedef logic [`SG_WORD_WIDTH-1:0]  sample_t;		// Unsigned, 0 is negative peak
	typedef logic [`SG_PHASE_WIDTH-1:0] phase_t;
	typedef logic [`SG_COUNT_WIDTH-1:0] freqCount_t;	// Overflows per gate

	// Digit 0 is the least significant
	typedef logic [`SG_DIGITS-1:0][3:0] bcd_t;

	typedef struct packed {
		logic increment;
		logic decrement;
	} encoderStep_t;

	typedef struct packed {
		tuningWord_t tuningWord;
		amplitude_t  amplitude;
	} ddsSettings_t;

endpackage

`default_nettype wire

// File: hw/Encoder.sv
// Quadrature rotary encoder decoder
// Synchronizes and debounces both lines, one step pulse per detent

`default_nettype none

`include "SignalGen_defs.svh"

module Encoder import SignalGenPkg::*; (
	input  wire          Clock,
	input  wire          Reset,
	input  wire          AsyncA_i,
	input  wire          AsyncB_i,
	output encoderStep_t Step_o
);

	localparam int CntWidth = $clog2(`SG_ENCODER_STABLE + 1);
	localparam int StableLast = `SG_ENCODER_STABLE - 1;

	// Bit 0 is line A, bit 1 is line B
	logic [1:0] meta;
	logic [1:0] sync;
	logic [1:0] level;		// Debounced
	logic [1:0] levelDly;
	logic [CntWidth-1:0] stableCnt [2];

	// Two-flop synchronizer, lines idle high
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			meta <= 2'b11;
			sync <= 2'b11;
		end else begin
			meta <= {AsyncB_i, AsyncA_i};
			sync <= meta;
		end
	end

	// A new level is taken once it has held for the stable time
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			for (int i = 0; i < 2; i++) begin
				stableCnt[i] <= '0;
			end
			level <= 2'b11;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (sync[i] == level[i]) begin
					stableCnt[i] <= '0;				// Bounce back, start over
				end else if (stableCnt[i] == CntWidth'(StableLast)) begin
					stableCnt[i] <= '0;
					level[i] <= sync[i];
				end else begin
					stableCnt[i] <= stableCnt[i] + 1'b1;
				end
			end
		end
	end

	// Detent ends on falling A, direction from B
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			levelDly <= 2'b11;
			Step_o <= '0;
		end else begin
			levelDly <= level;
			Step_o.increment <= levelDly[0] & ~level[0] & level[1];
			Step_o.decrement <= levelDly[0] & ~level[0] & ~level[1];
		end
	end

endmodule

`default_nettype wire

// File: hw/ParameterControl.sv
// Tuning word and amplitude settings
// Two encoders step wrapping 8-bit registers up and down

`default_nettype none

module ParameterControl import SignalGenPkg::*; (
	input  wire          Clock,
	input  wire          Reset,
	input  wire          FreqA_i,
	input  wire          FreqB_i,
	input  wire          AmplA_i,
	input  wire          AmplB_i,
	output ddsSettings_t Settings_o
);

	encoderStep_t freqStep;
	encoderStep_t amplStep;

	Encoder freqEncoder (
		.Clock    (Clock),
		.Reset    (Reset),
		.AsyncA_i (FreqA_i),
		.AsyncB_i (FreqB_i),
		.Step_o   (freqStep)
	);

	Encoder amplEncoder (
		.Clock    (Clock),
		.Reset    (Reset),
		.AsyncA_i (AmplA_i),
		.AsyncB_i (AmplB_i),
		.Step_o   (amplStep)
	);

	// Both settings wrap modulo 256, increment wins a tie
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Settings_o.tuningWord <= '0;
			Settings_o.amplitude <= '1;		// Full scale
		end else begin
			if (freqStep.increment)
				Settings_o.tuningWord <= Settings_o.tuningWord + 1'b1;
			else if (freqStep.decrement)
				Settings_o.tuningWord <= Settings_o.tuningWord - 1'b1;

			if (amplStep.increment)
				Settings_o.amplitude <= Settings_o.amplitude + 1'b1;
			else if (amplStep.decrement)
				Settings_o.amplitude <= Settings_o.amplitude - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/Dds.sv
// Direct digital synthesis core
// Phase accumulator, sine lookup and amplitude scaling

`default_nettype none

`include "SignalGen_defs.svh"

module Dds import SignalGenPkg::*; (
	input  wire          Clock,
	input  wire          Reset,
	input  ddsSettings_t Settings_i,
	output sample_t      Signal_o,
	output logic         Overflow_o
);

	localparam int TableSize = 1 << `SG_WORD_WIDTH;
	localparam int ProductWidth = 2 * `SG_WORD_WIDTH;

	// Start at the negative peak so the output rises from 0
	localparam phase_t PhaseStart = phase_t'(3 << (`SG_PHASE_WIDTH - 2));

	typedef sample_t [TableSize-1:0] sineTable_t;

	// Entry k = 127.5 + 127.5 * sin(2*pi*k/N), rounded
	function automatic sineTable_t makeSineTable();
		sineTable_t table_;
		real angle;
		for (int k = 0; k < TableSize; k++) begin
			angle = 2.0 * 3.14159265358979 * k / TableSize;
			table_[k] = sample_t'(int'(127.5 + 127.5 * $sin(angle)));
		end
		return table_;
	endfunction

	localparam sineTable_t SineTable = makeSineTable();

	phase_t phase;
	logic [`SG_PHASE_WIDTH:0] phaseSum;		// Extra bit is the carry
	sample_t sample;
	logic [ProductWidth-1:0] product;

	assign phaseSum = {1'b0, phase} + Settings_i.tuningWord;

	// Accumulator and carry strobe
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			phase <= PhaseStart;
			Overflow_o <= 1'b0;
		end else begin
			phase <= phaseSum[`SG_PHASE_WIDTH-1:0];
			Overflow_o <= phaseSum[`SG_PHASE_WIDTH];
		end
	end

	// Table index is the top byte of the phase
	assign product = sample * Settings_i.amplitude;

	// Two stages behind the accumulator
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			sample <= '0;
			Signal_o <= '0;
		end else begin
			sample <= SineTable[phase[`SG_PHASE_WIDTH-1 -: `SG_WORD_WIDTH]];
			Signal_o <= product[ProductWidth-1 -: `SG_WORD_WIDTH];	// Divide by 256
		end
	end

endmodule

`default_nettype wire

// File: hw/FrequencyMeter.sv
// Frequency meter
// Counts rising edges of the input over a one second gate

`default_nettype none

module FrequencyMeter import SignalGenPkg::*; #(
	parameter int ClockHz = 25_000_000
)(
	input  wire        Clock,
	input  wire        Reset,
	input  wire        Overflow_i,
	output freqCount_t Count_o,
	output logic       CountValid_o
);

	localparam int GateWidth = $clog2(ClockHz + 1);
	localparam int GateLast = ClockHz - 1;

	logic [2:0] inShift;		// Two sync stages plus one for the edge
	logic risingEdge;
	logic [GateWidth-1:0] gateCnt;
	freqCount_t edgeCount;

	// Input treated as asynchronous
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset)
			inShift <= '0;
		else
			inShift <= {inShift[1:0], Overflow_i};
	end

	assign risingEdge = inShift[1] & ~inShift[2];

	// Gate of ClockHz cycles, count latched at its end
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			gateCnt <= '0;
			edgeCount <= '0;
			Count_o <= '0;
			CountValid_o <= 1'b0;
		end else if (gateCnt == GateWidth'(GateLast)) begin
			gateCnt <= '0;
			edgeCount <= '0;
			Count_o <= edgeCount + freqCount_t'(risingEdge);	// Last cycle of the gate
			CountValid_o <= 1'b1;
		end else begin
			gateCnt <= gateCnt + 1'b1;
			edgeCount <= edgeCount + freqCount_t'(risingEdge);
			CountValid_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/SevenSegmentDisplay.sv
// Eight digit multiplexed seven segment display
// Double dabble conversion, digit scan and active low segment decode

`default_nettype none

`include "SignalGen_defs.svh"

module SevenSegmentDisplay import SignalGenPkg::*; #(
	parameter int ClockHz = 25_000_000
)(
	input  wire                    Clock,
	input  wire                    Reset,
	input  freqCount_t             Count_i,
	input  wire                    CountValid_i,
	output logic [`SG_DIGITS-1:0]  Cathodes_o,
	output logic [7:0]             Segments_o	// {a, b, c, d, e, f, g, dp}
);

	localparam int RefreshDiv = (ClockHz / 8000 < 1) ? 1 : ClockHz / 8000;
	localparam int RefreshWidth = $clog2(RefreshDiv + 1);
	localparam int ShiftWidth = $clog2(`SG_COUNT_WIDTH + 1);
	localparam int SelWidth = $clog2(`SG_DIGITS);

	typedef enum logic {Idle, Shift} convState_t;

	convState_t state;
	freqCount_t binary;
	bcd_t work;
	bcd_t adjusted;
	bcd_t shifted;
	bcd_t digits;			// Shown on the display
	logic [ShiftWidth-1:0] shiftCnt;
	logic done;
	logic [RefreshWidth-1:0] refreshCnt;
	logic [SelWidth-1:0] digitSel;

	// Add 3 to digits of 5 or more, then shift in the next bit
	always_comb begin
		for (int d = 0; d < `SG_DIGITS; d++)
			adjusted[d] = (work[d] >= 4'd5) ? work[d] + 4'd3 : work[d];
		shifted[0] = {adjusted[0][2:0], binary[`SG_COUNT_WIDTH-1]};
		for (int d = 1; d < `SG_DIGITS; d++)
			shifted[d] = {adjusted[d][2:0], adjusted[d-1][3]};
	end

	assign done = (shiftCnt == ShiftWidth'(`SG_COUNT_WIDTH - 1));

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			state <= Idle;
			binary <= '0;
			work <= '0;
			shiftCnt <= '0;
			digits <= '0;
		end else if (state == Idle) begin
			if (CountValid_i) begin
				binary <= Count_i;
				work <= '0;
				shiftCnt <= '0;
				state <= Shift;
			end
		end else begin
			binary <= binary << 1;
			work <= shifted;
			shiftCnt <= shiftCnt + 1'b1;
			if (done) begin
				digits <= shifted;		// Last shift goes straight out
				state <= Idle;
			end
		end
	end

	// Active high segments abcdefg, blank for non-decimal codes
	function automatic logic [6:0] decodeDigit(input logic [3:0] value);
		case (value)
			4'd0:    return 7'b1111110;
			4'd1:    return 7'b0110000;
			4'd2:    return 7'b1101101;
			4'd3:    return 7'b1111001;
			4'd4:    return 7'b0110011;
			4'd5:    return 7'b1011011;
			4'd6:    return 7'b1011111;
			4'd7:    return 7'b1110000;
			4'd8:    return 7'b1111111;
			4'd9:    return 7'b1111011;
			default: return 7'b0000000;
		endcase
	endfunction

	// Scan one digit per refresh tick, leading zeros shown
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			refreshCnt <= '0;
			digitSel <= '0;
			Cathodes_o <= '1;		// All off
			Segments_o <= '1;
		end else begin
			if (refreshCnt == RefreshWidth'(RefreshDiv - 1)) begin
				refreshCnt <= '0;
				digitSel <= digitSel + 1'b1;
			end else begin
				refreshCnt <= refreshCnt + 1'b1;
			end
			Cathodes_o <= ~(`SG_DIGITS'(1) << digitSel);
			Segments_o <= {~decodeDigit(digits[digitSel]), 1'b1};	// dp off
		end
	end

endmodule

`default_nettype wire

// File: hw/SignalGenerator.sv
// DDS signal generator top level
// Encoder settings feed the DDS core and a frequency meter with display

`default_nettype none

`include "SignalGen_defs.svh"

module SignalGenerator import SignalGenPkg::*; #(
	parameter int ClockHz = 25_000_000
)(
	input  wire                   Clock,
	input  wire                   Reset,
	input  wire                   EncoderFreqA_i,
	input  wire                   EncoderFreqB_i,
	input  wire                   EncoderAmplA_i,
	input  wire                   EncoderAmplB_i,
	output sample_t               Signal_o,
	output logic [`SG_DIGITS-1:0] Cathodes_o,
	output logic [7:0]            Segments_o
);

	ddsSettings_t settings;
	logic overflow;
	freqCount_t count;
	logic countValid;

	ParameterControl paramControl (
		.Clock      (Clock),
		.Reset      (Reset),
		.FreqA_i    (EncoderFreqA_i),
		.FreqB_i    (EncoderFreqB_i),
		.AmplA_i    (EncoderAmplA_i),
		.AmplB_i    (EncoderAmplB_i),
		.Settings_o (settings)
	);

	Dds dds (
		.Clock      (Clock),
		.Reset      (Reset),
		.Settings_i (settings),
		.Signal_o   (Signal_o),
		.Overflow_o (overflow)
	);

	// Meter sees the carry out of the accumulator
	FrequencyMeter #(.ClockHz(ClockHz)) freqMeter (
		.Clock        (Clock),
		.Reset        (Reset),
		.Overflow_i   (overflow),
		.Count_o      (count),
		.CountValid_o (countValid)
	);

	SevenSegmentDisplay #(.ClockHz(ClockHz)) display (
		.Clock        (Clock),
		.Reset        (Reset),
		.Count_i      (count),
		.CountValid_i (countValid),
		.Cathodes_o   (Cathodes_o),
		.Segments_o   (Segments_o)
	);

endmodule

`default_nettype wire

// File: testbench/SignalGeneratorTb.sv
// Testbench for the DDS signal generator
// Drives both encoders from an LCG, decodes the display and checks against a model

`default_nettype none

module SignalGeneratorTb import SignalGenPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int GateCycles = 65536;		// Used as ClockHz so the display reads the tuning word
	localparam int HoldCycles = 8;
	localparam int SettleCycles = 300;		// Conversion plus a few scans
	localparam int TimeoutCycles = 20 * GateCycles + 20000;

	logic Clock;
	logic Reset;
	logic freqA;
	logic freqB;
	logic amplA;
	logic amplB;
	sample_t signal;
	logic [7:0] cathodes;
	logic [7:0] segments;

	logic [31:0] lcgState = 32'h4196_8115;
	logic [7:0] modelTuning;
	logic [7:0] modelAmpl;
	int shown [8];			// Last digit seen per cathode
	int cycleCount;
	int peak;
	int trough;

	SignalGenerator #(.ClockHz(GateCycles)) dut0 (
		.Clock          (Clock),
		.Reset          (Reset),
		.EncoderFreqA_i (freqA),
		.EncoderFreqB_i (freqB),
		.EncoderAmplA_i (amplA),
		.EncoderAmplB_i (amplB),
		.Signal_o       (signal),
		.Cathodes_o     (cathodes),
		.Segments_o     (segments)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkEqual(input string testName, input int expected, input int actual);
		assert (expected == actual) else
			stopWithFailure($sformatf("Mismatch in %s: expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return {8'h00, lcgState[31:8]};		// Upper bits have the longer period
	endfunction

	function automatic int randomBelow(input int limit);
		return int'(nextRandom() % limit);
	endfunction

	// Active low {a..g, dp} back to a decimal digit or 15 if unknown
	function automatic int segmentsToDigit(input logic [7:0] seg);
		logic [6:0] lit;
		lit = ~seg[7:1];
		if (seg[0] !== 1'b1)
			return 15;				// dp must stay dark
		case (lit)
			7'b1111110: return 0;
			7'b0110000: return 1;
			7'b1101101: return 2;
			7'b1111001: return 3;
			7'b0110011: return 4;
			7'b1011011: return 5;
			7'b1011111: return 6;
			7'b1110000: return 7;
			7'b1111111: return 8;
			7'b1111011: return 9;
			default:    return 15;
		endcase
	endfunction

	function automatic int displayedValue();
		int value;
		value = 0;
		for (int i = 7; i >= 0; i--)
			value = value * 10 + shown[i];
		return value;
	endfunction

	// One level of a quadrature sequence
	task automatic setLines(input bit amplChannel, input logic a, input logic b);
		if (amplChannel) begin
			amplA = a;
			amplB = b;
		end else begin
			freqA = a;
			freqB = b;
		end
		repeat (HoldCycles) @(negedge Clock);
	endtask

	// One detent from rest with the matching model update
	task automatic driveDetent(input bit amplChannel, input bit up);
		if (up) begin
			setLines(amplChannel, 1'b0, 1'b1);
			setLines(amplChannel, 1'b0, 1'b0);
			setLines(amplChannel, 1'b1, 1'b0);
		end else begin
			setLines(amplChannel, 1'b1, 1'b0);
			setLines(amplChannel, 1'b0, 1'b0);
			setLines(amplChannel, 1'b0, 1'b1);
		end
		setLines(amplChannel, 1'b1, 1'b1);
		if (amplChannel)
			modelAmpl = up ? modelAmpl + 8'd1 : modelAmpl - 8'd1;
		else
			modelTuning = up ? modelTuning + 8'd1 : modelTuning - 8'd1;
	endtask

	task automatic randomSteps(input bit amplChannel, input int count);
		repeat (count) driveDetent(amplChannel, randomBelow(2) == 1);
	endtask

	// Shortest way round the 256 wrap
	task automatic setTuning(input logic [7:0] target);
		logic [7:0] diff;
		while (modelTuning != target) begin
			diff = target - modelTuning;
			driveDetent(1'b0, diff < 8'd128);
		end
	endtask

	task automatic setAmplitude(input logic [7:0] target);
		logic [7:0] diff;
		while (modelAmpl != target) begin
			diff = target - modelAmpl;
			driveDetent(1'b1, diff < 8'd128);
		end
	endtask

	task automatic watchSignal(input int cycles, output int maxV, output int minV);
		maxV = 0;
		minV = 255;
		repeat (cycles) begin
			@(negedge Clock);
			if (int'(signal) > maxV) maxV = int'(signal);
			if (int'(signal) < minV) minV = int'(signal);
		end
	endtask

	task automatic checkDisplayAfterGates(input string testName);
		repeat (2 * GateCycles + SettleCycles) @(negedge Clock);
		checkEqual(testName, int'(modelTuning), displayedValue());
	endtask

	// Display decoder sampling on the falling edge
	always @(negedge Clock) begin : decodeDisplay
		int lowCount;
		int idx;
		int digit;
		if (Reset === 1'b1) begin
			lowCount = $countones(~cathodes);
			assert (lowCount <= 1) else
				stopWithFailure("More than one cathode was driven low at the same time");
			if (lowCount == 1) begin
				idx = 0;
				for (int i = 0; i < 8; i++)
					if (!cathodes[i]) idx = i;
				digit = segmentsToDigit(segments);
				assert (digit != 15) else
					stopWithFailure($sformatf("Unknown segment pattern %b on digit %0d",
						segments, idx));
				shown[idx] = digit;
			end
		end
	end

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
			stopWithFailure("Timeout: the tests did not finish within the cycle limit");
	end

	initial begin
		Reset = 1'b0;
		freqA = 1'b1;
		freqB = 1'b1;
		amplA = 1'b1;
		amplB = 1'b1;
		modelTuning = 8'd0;
		modelAmpl = 8'd255;
		for (int i = 0; i < 8; i++)
			shown[i] = 0;
		repeat (10) @(negedge Clock);
		Reset = 1'b1;

		// Quiet output through the first gate
		repeat (GateCycles + SettleCycles) begin
			@(negedge Clock);
			checkEqual("reset signal", 0, int'(signal));
		end
		checkEqual("reset display", 0, displayedValue());

		randomSteps(1'b0, 5 + randomBelow(20));
		checkDisplayAfterGates("random frequency steps");

		setTuning(8'd0);
		driveDetent(1'b0, 1'b0);		// 0 wraps to 255
		checkDisplayAfterGates("tuning wrap");

		// Tuning 16 gives a 4096 cycle period
		setTuning(8'd16);
		randomSteps(1'b1, 10 + randomBelow(30));
		repeat (4) @(negedge Clock);
		watchSignal(4096, peak, trough);
		checkEqual("amplitude peak", 255 * int'(modelAmpl) / 256, peak);
		checkEqual("amplitude trough", 0, trough);

		setAmplitude(8'd255);
		repeat (4) @(negedge Clock);
		watchSignal(4096, peak, trough);
		checkEqual("full scale peak", 254, peak);
		driveDetent(1'b1, 1'b1);
		repeat (4) @(negedge Clock);
		watchSignal(4096, peak, trough);
		checkEqual("amplitude wrap", 0, peak);

		fork
			randomSteps(1'b0, 8 + randomBelow(12));
			randomSteps(1'b1, 8 + randomBelow(12));
		join
		if (modelTuning == 8'd0)
			driveDetent(1'b0, 1'b1);		// Phase must move for a peak
		repeat (4) @(negedge Clock);
		watchSignal(2 * GateCycles + SettleCycles, peak, trough);
		checkEqual("interleaved amplitude peak", 255 * int'(modelAmpl) / 256, peak);
		checkEqual("interleaved frequency", int'(modelTuning), displayedValue());

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/SignalGenPkg.sv
hw/Encoder.sv
hw/ParameterControl.sv
hw/Dds.sv
hw/FrequencyMeter.sv
hw/SevenSegmentDisplay.sv
hw/SignalGenerator.sv
testbench/SignalGeneratorTb.sv

// File: run.sh
#!/bin/sh
# Build and run the signal generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f list.f --top-module SignalGeneratorTb -o simSignalGenerator

./obj_dir/simSignalGenerator | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
grep -q ">>> PASS" sim.log
